//--- source/ctrl_pkg.sv
//////////////////////////////////////////////////
// shared types for the core controller blocks
// import with ctrl_pkg::* in the module header
//////////////////////////////////////////////////

`default_nettype none

package ctrl_pkg;

  // register file index width, fixed for RV32I
  localparam int unsigned REG_ADDR_W = 5;

  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // one write-back port seen by the ID stage
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
  } wr_port_t;

  // jump kind as reported by the decoder
  typedef enum logic [1:0] {
    NONE = 2'b00,
    JAL  = 2'b01,
    JALR = 2'b10,
    COND = 2'b11
  } jump_e;

  // fetch stage pc source
  typedef enum logic [1:0] {
    PC_BOOT      = 2'b00,
    PC_JUMP      = 2'b01,
    PC_BRANCH    = 2'b10,
    PC_EXCEPTION = 2'b11
  } pc_mux_e;

  // operand source in front of the ID stage operand muxes
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fw_sel_e;

  // pc set strobe travels with its selector
  typedef struct packed {
    logic    set;
    pc_mux_e sel;
  } pc_ctrl_t;

  // one bit per write port and read operand pair
  typedef struct packed {
    logic ex_a;
    logic ex_b;
    logic wb_a;
    logic wb_b;
    logic alu_a;
    logic alu_b;
  } fw_match_t;

  // controller fsm states
  typedef enum logic [2:0] {
    RESET       = 3'd0,
    BOOT_SET    = 3'd1,
    SLEEP       = 3'd2,
    FIRST_FETCH = 3'd3,
    DECODE      = 3'd4,
    FLUSH_EX    = 3'd5,
    FLUSH_WB    = 3'd6
  } ctrl_state_e;

endpackage

`default_nettype wire

//--- source/reg_match.sv
//////////////////////////////////////////////////
// register address compare for operand forwarding
// checks both ID read ports against three writers
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module reg_match
  import ctrl_pkg::*;
(
  input  wire reg_addr_t raddr_a_i,
  input  wire reg_addr_t raddr_b_i,
  input  wire logic      rega_used_i,
  input  wire logic      regb_used_i,
  input  wire wr_port_t  wr_ex_i,
  input  wire wr_port_t  wr_wb_i,
  input  wire wr_port_t  wr_alu_i,
  output fw_match_t      match_o
);

  // a writer hits a reader when it writes, the operand is read,
  // and both name the same register other than x0
  function automatic logic port_hit(input wr_port_t  port,
                                    input reg_addr_t raddr,
                                    input logic      used);
    logic same;
    same = (port.addr == raddr);
    return port.we & used & same & (raddr != '0);
  endfunction

  always_comb
  begin
    // operand a
    match_o.ex_a  = port_hit(wr_ex_i,  raddr_a_i, rega_used_i);
    match_o.wb_a  = port_hit(wr_wb_i,  raddr_a_i, rega_used_i);
    match_o.alu_a = port_hit(wr_alu_i, raddr_a_i, rega_used_i);
    // operand b
    match_o.ex_b  = port_hit(wr_ex_i,  raddr_b_i, regb_used_i);
    match_o.wb_b  = port_hit(wr_wb_i,  raddr_b_i, regb_used_i);
    match_o.alu_b = port_hit(wr_alu_i, raddr_b_i, regb_used_i);
  end

  // x0 is hardwired to zero, so nothing may ever be forwarded for it
  always_comb
  begin
    if (raddr_a_i == '0)
      assert (!(match_o.ex_a | match_o.wb_a | match_o.alu_a))
        else $error("forward match on x0 for operand a");
    if (raddr_b_i == '0)
      assert (!(match_o.ex_b | match_o.wb_b | match_o.alu_b))
        else $error("forward match on x0 for operand b");
  end

endmodule

`default_nettype wire

//--- source/hazard_unit.sv
//////////////////////////////////////////////////
// stall, write-enable kill and forwarding selects
// fed by reg_match, all paths combinational
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module hazard_unit
  import ctrl_pkg::*;
(
  input  wire fw_match_t match_i,
  input  wire logic      data_req_ex_i,
  input  wire jump_e     jump_in_dec_i,
  input  wire logic      is_decoding_i,
  output fw_sel_e        fw_sel_a_o,
  output fw_sel_e        fw_sel_b_o,
  output logic           load_stall_o,
  output logic           jr_stall_o,
  output logic           deassert_we_o
);

  logic a_any_match;

  //////////////////////////////////////////////////
  // stalls
  //////////////////////////////////////////////////

  // jalr target needs operand a, any pending writer blocks it
  assign a_any_match = match_i.ex_a | match_i.wb_a | match_i.alu_a;

  always_comb
  begin
    // load in EX writes a register that ID reads now
    load_stall_o = data_req_ex_i & (match_i.ex_a | match_i.ex_b);

    // jump register hazard, independent of the fsm decode flag
    jr_stall_o = (jump_in_dec_i == JALR) & a_any_match;

    // kill the ID instruction's side effects
    // when not decoding or while stalled
    deassert_we_o = ~is_decoding_i | load_stall_o | jr_stall_o;
  end

  //////////////////////////////////////////////////
  // forwarding select
  //////////////////////////////////////////////////

  always_comb
  begin
    // ALU result in EX is the youngest, it wins over WB
    if (match_i.alu_a)
      fw_sel_a_o = SEL_FW_EX;
    else if (match_i.wb_a)
      fw_sel_a_o = SEL_FW_WB;
    else
      fw_sel_a_o = SEL_REGFILE;

    // same priority for operand b
    if (match_i.alu_b)
      fw_sel_b_o = SEL_FW_EX;
    else if (match_i.wb_b)
      fw_sel_b_o = SEL_FW_WB;
    else
      fw_sel_b_o = SEL_REGFILE;
  end

endmodule

`default_nettype wire

//--- source/ctrl_fsm.sv
//////////////////////////////////////////////////
// main control fsm: boot, sleep, decode, flush
// drives pc set/select, halts, fetch request
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ctrl_fsm
  import ctrl_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  rst_n,
  input  wire logic  fetch_enable_i,
  input  wire logic  instr_valid_i,
  input  wire logic  branch_taken_ex_i,
  input  wire logic  exc_req_i,
  input  wire logic  pipe_flush_i,
  input  wire logic  id_ready_i,
  input  wire logic  ex_valid_i,
  input  wire logic  jr_stall_i,
  input  wire jump_e jump_in_dec_i,
  output pc_ctrl_t   pc_ctrl_o,
  output logic       instr_req_o,
  output logic       ctrl_busy_o,
  output logic       is_decoding_o,
  output logic       halt_if_o,
  output logic       halt_id_o,
  output logic       exc_ack_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // blocks a second pc set for the jump that sits in ID
  logic jump_done_q;
  logic jump_done_d;

  logic is_uncond_jump;

  assign is_uncond_jump = (jump_in_dec_i == JAL) || (jump_in_dec_i == JALR);

  //////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////

  always_comb
  begin
    // defaults for a running core
    instr_req_o   = 1'b1;
    ctrl_busy_o   = 1'b1;
    is_decoding_o = 1'b0;
    halt_if_o     = 1'b0;
    halt_id_o     = 1'b0;
    exc_ack_o     = 1'b0;
    pc_ctrl_o.set = 1'b0;
    pc_ctrl_o.sel = PC_BOOT;
    jump_done_d   = jump_done_q;
    state_d       = state_q;

    case (state_q)
      // idle after reset until fetch is enabled
      RESET:
      begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        if (fetch_enable_i)
          state_d = BOOT_SET;
      end

      // load the boot address into the fetch pc, one cycle only
      BOOT_SET:
      begin
        pc_ctrl_o.set = 1'b1;
        pc_ctrl_o.sel = PC_BOOT;
        state_d       = FIRST_FETCH;
      end

      // pipeline is empty, fetch stopped
      SLEEP:
      begin
        instr_req_o = 1'b0;
        ctrl_busy_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        // an exception request also wakes the core
        if (fetch_enable_i || exc_req_i)
          state_d = FIRST_FETCH;
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH:
      begin
        if (id_ready_i)
          state_d = DECODE;
        if (exc_req_i)
        begin
          pc_ctrl_o.set = 1'b1;
          pc_ctrl_o.sel = PC_EXCEPTION;
          exc_ack_o     = 1'b1;
        end
      end

      DECODE:
      begin
        // only decode when no taken branch in EX kills this instruction
        if (instr_valid_i && !branch_taken_ex_i)
        begin
          is_decoding_o = 1'b1;

          if (is_uncond_jump)
          begin
            // target is known in ID, jump right away
            pc_ctrl_o.sel = PC_JUMP;
            // wait for a jr hazard to clear, and set once per jump
            if (!jr_stall_i && !jump_done_q)
            begin
              pc_ctrl_o.set = 1'b1;
              jump_done_d   = 1'b1;
            end
          end
          else if (exc_req_i)
          begin
            pc_ctrl_o.set = 1'b1;
            pc_ctrl_o.sel = PC_EXCEPTION;
            exc_ack_o     = 1'b1;
            // the faulting instruction must not enter EX
            halt_id_o     = 1'b1;
          end

          // wfi, drain EX and WB before sleeping
          if (pipe_flush_i)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = FLUSH_EX;
          end
        end

        // taken branch in EX overrides whatever ID holds
        if (branch_taken_ex_i)
        begin
          pc_ctrl_o.set = 1'b1;
          pc_ctrl_o.sel = PC_BRANCH;
          is_decoding_o = 1'b0;
        end
      end

      // bubble into EX, wait until EX has finished
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          state_d = FLUSH_WB;
      end

      // last flush cycle, resume or go to sleep
      FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (fetch_enable_i)
        begin
          halt_if_o = 1'b0;
          state_d   = DECODE;
        end
        else
        begin
          state_d = SLEEP;
        end
      end

      // unused encoding
      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // state registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // the jump leaves ID once ID accepts the next instruction
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

  // without branch prediction EX can not resolve two taken branches back to back
  assert property (@(posedge clk) disable iff (!rst_n)
                   branch_taken_ex_i |=> !branch_taken_ex_i)
    else $error("taken branch in two consecutive cycles");

endmodule

`default_nettype wire

//--- source/core_controller.sv
//////////////////////////////////////////////////
// core controller top, joins the fsm with the
// address compare and the hazard/forwarding unit
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module core_controller
  import ctrl_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst_n,
  input  wire logic      fetch_enable_i,
  // decoder
  input  wire logic      pipe_flush_i,
  input  wire logic      instr_valid_i,
  input  wire jump_e     jump_in_dec_i,
  input  wire jump_e     jump_in_id_i,
  // register reads in ID
  input  wire reg_addr_t raddr_a_i,
  input  wire reg_addr_t raddr_b_i,
  input  wire logic      rega_used_i,
  input  wire logic      regb_used_i,
  // pending write-backs
  input  wire wr_port_t  wr_ex_i,
  input  wire wr_port_t  wr_wb_i,
  input  wire wr_port_t  wr_alu_i,
  // EX stage and exceptions
  input  wire logic      data_req_ex_i,
  input  wire logic      branch_taken_ex_i,
  input  wire logic      exc_req_i,
  // stage handshake
  input  wire logic      id_ready_i,
  input  wire logic      ex_valid_i,
  // fetch and pipeline control
  output pc_ctrl_t       pc_ctrl_o,
  output logic           instr_req_o,
  output logic           ctrl_busy_o,
  output logic           is_decoding_o,
  output logic           halt_if_o,
  output logic           halt_id_o,
  output logic           exc_ack_o,
  // hazards and forwarding
  output fw_sel_e        fw_sel_a_o,
  output fw_sel_e        fw_sel_b_o,
  output logic           load_stall_o,
  output logic           jr_stall_o,
  output logic           deassert_we_o
);

  fw_match_t fw_match;

  // address compare
  reg_match reg_match_inst (
    .raddr_a_i   (raddr_a_i),
    .raddr_b_i   (raddr_b_i),
    .rega_used_i (rega_used_i),
    .regb_used_i (regb_used_i),
    .wr_ex_i     (wr_ex_i),
    .wr_wb_i     (wr_wb_i),
    .wr_alu_i    (wr_alu_i),
    .match_o     (fw_match)
  );

  // stalls and forwarding selects
  hazard_unit hazard_unit_inst (
    .match_i       (fw_match),
    .data_req_ex_i (data_req_ex_i),
    .jump_in_dec_i (jump_in_dec_i),
    .is_decoding_i (is_decoding_o),
    .fw_sel_a_o    (fw_sel_a_o),
    .fw_sel_b_o    (fw_sel_b_o),
    .load_stall_o  (load_stall_o),
    .jr_stall_o    (jr_stall_o),
    .deassert_we_o (deassert_we_o)
  );

  // control fsm
  ctrl_fsm ctrl_fsm_inst (
    .clk               (clk),
    .rst_n             (rst_n),
    .fetch_enable_i    (fetch_enable_i),
    .instr_valid_i     (instr_valid_i),
    .branch_taken_ex_i (branch_taken_ex_i),
    .exc_req_i         (exc_req_i),
    .pipe_flush_i      (pipe_flush_i),
    .id_ready_i        (id_ready_i),
    .ex_valid_i        (ex_valid_i),
    .jr_stall_i        (jr_stall_o),
    .jump_in_dec_i     (jump_in_dec_i),
    .pc_ctrl_o         (pc_ctrl_o),
    .instr_req_o       (instr_req_o),
    .ctrl_busy_o       (ctrl_busy_o),
    .is_decoding_o     (is_decoding_o),
    .halt_if_o         (halt_if_o),
    .halt_id_o         (halt_id_o),
    .exc_ack_o         (exc_ack_o)
  );

  // the gated jump in ID is the decoder's jump or nothing
  assert property (@(posedge clk) disable iff (!rst_n)
                   (jump_in_id_i != NONE) |-> (jump_in_id_i == jump_in_dec_i))
    else $error("jump kind in ID differs from the decoder");

endmodule

`default_nettype wire

//--- tb/core_controller_tb.sv
//////////////////////////////////////////////////
// table driven testbench for the core controller
// vectors step boot, forwarding, stalls, jumps,
// branch, exception and the wfi flush into sleep
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module core_controller_tb
  import ctrl_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 5;

  // short names for the table columns
  localparam fw_sel_e  RF = SEL_REGFILE;
  localparam fw_sel_e  FX = SEL_FW_EX;
  localparam fw_sel_e  FW = SEL_FW_WB;
  localparam wr_port_t NO_WR = '0;
  localparam pc_ctrl_t NO_PC      = '{set: 1'b0, sel: PC_BOOT};
  localparam pc_ctrl_t HOLD_JUMP  = '{set: 1'b0, sel: PC_JUMP};
  localparam pc_ctrl_t SET_BOOT   = '{set: 1'b1, sel: PC_BOOT};
  localparam pc_ctrl_t SET_JUMP   = '{set: 1'b1, sel: PC_JUMP};
  localparam pc_ctrl_t SET_BRANCH = '{set: 1'b1, sel: PC_BRANCH};
  localparam pc_ctrl_t SET_EXC    = '{set: 1'b1, sel: PC_EXCEPTION};

  // ctl = {fetch_enable, pipe_flush, instr_valid, branch_taken,
  //        exc_req, id_ready, ex_valid, data_req_ex}
  typedef struct packed {
    logic [7:0] ctl;
    jump_e      jump;
    reg_addr_t  raddr_a;
    reg_addr_t  raddr_b;
    logic [1:0] used;
    wr_port_t   wr_ex;
    wr_port_t   wr_wb;
    wr_port_t   wr_alu;
  } stim_t;

  // flags = {instr_req, busy, is_decoding, halt_if, halt_id,
  //          exc_ack, load_stall, jr_stall, deassert_we}
  typedef struct packed {
    pc_ctrl_t   pc;
    logic [8:0] flags;
    fw_sel_e    fw_a;
    fw_sel_e    fw_b;
  } expect_t;

  typedef struct {
    string   name;
    stim_t   stim;
    expect_t exp;
  } vector_t;

  logic clk;
  logic rst_n;
  logic fetch_enable_i;
  logic pipe_flush_i;
  logic instr_valid_i;
  jump_e jump_in_dec_i;
  jump_e jump_in_id_i;
  reg_addr_t raddr_a_i;
  reg_addr_t raddr_b_i;
  logic rega_used_i;
  logic regb_used_i;
  wr_port_t wr_ex_i;
  wr_port_t wr_wb_i;
  wr_port_t wr_alu_i;
  logic data_req_ex_i;
  logic branch_taken_ex_i;
  logic exc_req_i;
  logic id_ready_i;
  logic ex_valid_i;
  pc_ctrl_t pc_ctrl_o;
  logic instr_req_o;
  logic ctrl_busy_o;
  logic is_decoding_o;
  logic halt_if_o;
  logic halt_id_o;
  logic exc_ack_o;
  fw_sel_e fw_sel_a_o;
  fw_sel_e fw_sel_b_o;
  logic load_stall_o;
  logic jr_stall_o;
  logic deassert_we_o;

  vector_t vectors[$];

  core_controller core_controller_inst (.*);

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  function automatic wr_port_t write_to(input reg_addr_t addr);
    wr_port_t p;
    p.we   = 1'b1;
    p.addr = addr;
    return p;
  endfunction

  function automatic void add_vec(input string name, input logic [7:0] ctl, input jump_e jump,
                                  input reg_addr_t ra, input reg_addr_t rb,
                                  input logic [1:0] used, input wr_port_t ex,
                                  input wr_port_t wb, input wr_port_t alu,
                                  input pc_ctrl_t pc, input logic [8:0] flags,
                                  input fw_sel_e fa, input fw_sel_e fb);
    vector_t v;
    v.name = name;
    v.stim = '{ctl, jump, ra, rb, used, ex, wb, alu};
    v.exp  = '{pc, flags, fa, fb};
    vectors.push_back(v);
  endfunction

  // expected values follow the controller rules state by state
  function automatic void build_table();
    // boot
    add_vec("reset idle", 8'b0000_0000, NONE, 5'd0, 5'd0, 2'b00, NO_WR, NO_WR, NO_WR,
            NO_PC, 9'b000_000_001, RF, RF);
    add_vec("fetch enable", 8'b1000_0000, NONE, 5'd0, 5'd0, 2'b00, NO_WR, NO_WR, NO_WR,
            NO_PC, 9'b000_000_001, RF, RF);
    add_vec("boot set", 8'b1000_0000, NONE, 5'd0, 5'd0, 2'b00, NO_WR, NO_WR, NO_WR,
            SET_BOOT, 9'b110_000_001, RF, RF);
    add_vec("first fetch wait", 8'b1000_0000, NONE, 5'd0, 5'd0, 2'b00, NO_WR, NO_WR, NO_WR,
            NO_PC, 9'b110_000_001, RF, RF);
    add_vec("first fetch ready", 8'b1000_0100, NONE, 5'd0, 5'd0, 2'b00, NO_WR, NO_WR, NO_WR,
            NO_PC, 9'b110_000_001, RF, RF);
    // forwarding priority in DECODE
    add_vec("fw alu over wb", 8'b1010_0100, NONE, 5'd5, 5'd6, 2'b11, NO_WR, write_to(5'd5),
            write_to(5'd5), NO_PC, 9'b111_000_000, FX, RF);
    add_vec("fw wb only", 8'b1010_0100, NONE, 5'd5, 5'd6, 2'b11, NO_WR, write_to(5'd6),
            NO_WR, NO_PC, 9'b111_000_000, RF, FW);
    add_vec("fw x0 ignored", 8'b1010_0100, NONE, 5'd0, 5'd0, 2'b11, NO_WR, write_to(5'd0),
            write_to(5'd0), NO_PC, 9'b111_000_000, RF, RF);
    add_vec("fw unused operand", 8'b1010_0100, NONE, 5'd5, 5'd7, 2'b01, NO_WR, NO_WR,
            write_to(5'd5), NO_PC, 9'b111_000_000, RF, RF);
    add_vec("load use stall", 8'b1010_0101, NONE, 5'd3, 5'd7, 2'b11, write_to(5'd7),
            write_to(5'd3), NO_WR, NO_PC, 9'b111_000_101, FW, RF);
    // jumps stay in ID while id_ready is low
    add_vec("jalr stall", 8'b1010_0000, JALR, 5'd4, 5'd0, 2'b10, write_to(5'd4), NO_WR,
            NO_WR, HOLD_JUMP, 9'b111_000_011, RF, RF);
    add_vec("jalr issue", 8'b1010_0000, JALR, 5'd4, 5'd0, 2'b10, NO_WR, NO_WR, NO_WR,
            SET_JUMP, 9'b111_000_000, RF, RF);
    add_vec("jalr held once", 8'b1010_0000, JALR, 5'd4, 5'd0, 2'b10, NO_WR, NO_WR, NO_WR,
            HOLD_JUMP, 9'b111_000_000, RF, RF);
    add_vec("jalr id ready", 8'b1010_0100, JALR, 5'd4, 5'd0, 2'b10, NO_WR, NO_WR, NO_WR,
            HOLD_JUMP, 9'b111_000_000, RF, RF);
    add_vec("jal next jump", 8'b1010_0000, JAL, 5'd0, 5'd0, 2'b00, NO_WR, NO_WR, NO_WR,
            SET_JUMP, 9'b111_000_000, RF, RF);
    // branch and exception
    add_vec("branch taken", 8'b1011_0100, NONE, 5'd0, 5'd0, 2'b00, NO_WR, NO_WR, NO_WR,
            SET_BRANCH, 9'b110_000_001, RF, RF);
    add_vec("decode exception", 8'b1010_1100, NONE, 5'd0, 5'd0, 2'b00, NO_WR, NO_WR, NO_WR,
            SET_EXC, 9'b111_011_000, RF, RF);
    // wfi flush with fetch disabled
    add_vec("wfi flush", 8'b0110_0100, NONE, 5'd0, 5'd0, 2'b00, NO_WR, NO_WR, NO_WR,
            NO_PC, 9'b111_110_000, RF, RF);
    add_vec("flush ex wait", 8'b0000_0000, NONE, 5'd0, 5'd0, 2'b00, NO_WR, NO_WR, NO_WR,
            NO_PC, 9'b110_110_001, RF, RF);
    add_vec("flush ex done", 8'b0000_0010, NONE, 5'd0, 5'd0, 2'b00, NO_WR, NO_WR, NO_WR,
            NO_PC, 9'b110_110_001, RF, RF);
    add_vec("flush wb", 8'b0000_0000, NONE, 5'd0, 5'd0, 2'b00, NO_WR, NO_WR, NO_WR,
            NO_PC, 9'b110_110_001, RF, RF);
    add_vec("sleep", 8'b0000_0000, NONE, 5'd0, 5'd0, 2'b00, NO_WR, NO_WR, NO_WR,
            NO_PC, 9'b000_110_001, RF, RF);
    add_vec("wake on exception", 8'b0000_1000, NONE, 5'd0, 5'd0, 2'b00, NO_WR, NO_WR, NO_WR,
            NO_PC, 9'b000_110_001, RF, RF);
    add_vec("fetch after wake", 8'b0000_0000, NONE, 5'd0, 5'd0, 2'b00, NO_WR, NO_WR, NO_WR,
            NO_PC, 9'b110_000_001, RF, RF);
    add_vec("first fetch exc", 8'b0000_1000, NONE, 5'd0, 5'd0, 2'b00, NO_WR, NO_WR, NO_WR,
            SET_EXC, 9'b110_001_001, RF, RF);
  endfunction

  task automatic apply_stim(input stim_t s);
    {fetch_enable_i, pipe_flush_i, instr_valid_i, branch_taken_ex_i,
     exc_req_i, id_ready_i, ex_valid_i, data_req_ex_i} = s.ctl;
    jump_in_dec_i = s.jump;
    // the ID copy of the jump follows the decoder
    jump_in_id_i = s.jump;
    raddr_a_i = s.raddr_a;
    raddr_b_i = s.raddr_b;
    {rega_used_i, regb_used_i} = s.used;
    wr_ex_i  = s.wr_ex;
    wr_wb_i  = s.wr_wb;
    wr_alu_i = s.wr_alu;
  endtask

  task automatic check_value(input string test, input string field,
                             input logic [15:0] exp, input logic [15:0] act);
    if (act !== exp)
    begin
      $display("Error %s (%s): expected %h actual %h", test, field, exp, act);
      $display("TEST FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  //////////////////////////////////////////////////
  // clock, watchdog, main sequence
  //////////////////////////////////////////////////

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // table is built at time zero, so its size is known here
  initial
  begin
    #1;
    #((vectors.size() + RESET_CYCLES + 20) * CLK_PERIOD);
    $display("TEST FAIL");
    $fatal(1, "watchdog expired before all vectors were applied");
  end

  initial
  begin
    logic [8:0] flags;
    build_table();
    rst_n = 1'b0;
    apply_stim('0);

    // outputs stay quiet while reset is held
    repeat (RESET_CYCLES)
    begin
      @(posedge clk);
      #(CLK_PERIOD - 1);
      check_value("reset", "instr_req", 16'd0, 16'(instr_req_o));
      check_value("reset", "busy", 16'd0, 16'(ctrl_busy_o));
      check_value("reset", "pc_set", 16'd0, 16'(pc_ctrl_o.set));
    end

    // drive 2 ns after the edge, sample 1 ns before the next one
    foreach (vectors[i])
    begin
      @(posedge clk);
      #2;
      rst_n = 1'b1;
      apply_stim(vectors[i].stim);
      #(CLK_PERIOD - 3);
      flags = {instr_req_o, ctrl_busy_o, is_decoding_o, halt_if_o, halt_id_o,
               exc_ack_o, load_stall_o, jr_stall_o, deassert_we_o};
      check_value(vectors[i].name, "pc_ctrl", 16'(vectors[i].exp.pc), 16'(pc_ctrl_o));
      check_value(vectors[i].name, "flags", 16'(vectors[i].exp.flags), 16'(flags));
      check_value(vectors[i].name, "fw_sel_a", 16'(vectors[i].exp.fw_a), 16'(fw_sel_a_o));
      check_value(vectors[i].name, "fw_sel_b", 16'(vectors[i].exp.fw_b), 16'(fw_sel_b_o));
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- core_controller.f
source/ctrl_pkg.sv
source/reg_match.sv
source/hazard_unit.sv
source/ctrl_fsm.sv
source/core_controller.sv
tb/core_controller_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator and run the core controller testbench
verilator --binary --timing --timescale 1ns/1ns --top-module core_controller_tb \
  -f core_controller.f -o sim_core_controller || exit 1
out=$(./obj_dir/sim_core_controller)
echo "$out"
echo "$out" | grep -q "TEST PASS" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
